/* hdl/dma_pkg.sv */
`default_nettype none

package dma_pkg;

  localparam int addr_w          = 64;
  localparam int data_w          = 512;
  localparam int cnt_w           = 32;
  localparam int log2_beat_bytes = 6;   // 64-byte bus beat
  localparam int queue_depth     = 4;
  localparam int queue_ptr_w     = $clog2(queue_depth);
  localparam int queue_cnt_w     = $clog2(queue_depth + 1);

  typedef enum logic [1:0] {
    mode_read  = 2'd1,
    mode_write = 2'd2
  } dma_mode_e;

  // common three-state walk of request generators and beat trackers
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_run  = 2'd1,
    st_done = 2'd2
  } fsm_state_e;

  typedef struct packed {
    dma_mode_e         mode;
    logic [addr_w-1:0] ext_addr;    // byte address
    logic [cnt_w-1:0]  len;         // beats per segment
    logic [cnt_w-1:0]  seg_stride;  // in bus words
    logic [cnt_w-1:0]  seg_count;
  } dma_desc_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [cnt_w-1:0]  len;         // beats minus one
  } burst_req_t;

  typedef struct packed {
    logic [cnt_w-1:0] len;
    logic [cnt_w-1:0] seg_count;
  } job_t;

endpackage

`default_nettype wire

/* hdl/dma_queue.sv */
`default_nettype none

module dma_queue import dma_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready,
  output logic     almost_full
);

  payload_t               mem [queue_depth];
  logic [queue_ptr_w-1:0] rd_ptr;
  logic [queue_ptr_w-1:0] wr_ptr;
  logic [queue_cnt_w-1:0] count;
  logic                   push;
  logic                   pop;

  assign in_ready    = (count != queue_cnt_w'(queue_depth));
  assign out_valid   = (count != '0);
  assign almost_full = (count >= queue_cnt_w'(queue_depth - 1));  // one free slot or less
  assign out_data    = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == queue_ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == queue_ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + queue_cnt_w'(push) - queue_cnt_w'(pop);
    end
  end

endmodule

`default_nettype wire

/* hdl/dma_dispatch.sv */
`default_nettype none

module dma_dispatch import dma_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      start,
  input  dma_desc_t cmd,
  output logic      queue_wr_ready,
  output dma_desc_t rd_desc,
  output logic      rd_desc_valid,
  input  logic      rd_desc_ready,
  output dma_desc_t wr_desc,
  output logic      wr_desc_valid,
  input  logic      wr_desc_ready,
  output job_t      rd_job,
  output logic      rd_job_valid,
  input  logic      rd_job_ready,
  output job_t      wr_job,
  output logic      wr_job_valid,
  input  logic      wr_job_ready
);

  logic      start_q;
  logic      start_pulse;
  logic      almost_full;
  dma_desc_t head;
  logic      head_valid;
  logic      head_ready;
  logic      head_rd;
  logic      head_wr;
  job_t      head_job;
  logic      rd_jobq_ready;
  logic      wr_jobq_ready;

  // edge register, then pulse register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start_q     <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      start_q     <= start;
      start_pulse <= start & ~start_q;
    end
  end

  assign queue_wr_ready = ~almost_full;

  // a push into a full queue is lost; queue_wr_ready warns the host early
  dma_queue #(.payload_t(dma_desc_t)) u_desc_q (
    .clk(clk), .arst_n(arst_n),
    .in_data(cmd), .in_valid(start_pulse), .in_ready(),
    .out_data(head), .out_valid(head_valid), .out_ready(head_ready),
    .almost_full(almost_full)
  );

  assign head_rd  = head_valid & (head.mode == mode_read);
  assign head_wr  = head_valid & (head.mode == mode_write);
  assign head_job = '{len: head.len, seg_count: head.seg_count};

  // generator and job queue take the head in the same cycle
  assign rd_desc       = head;
  assign wr_desc       = head;
  assign rd_desc_valid = head_rd & rd_jobq_ready;
  assign wr_desc_valid = head_wr & wr_jobq_ready;

  assign head_ready = (head_rd & rd_desc_ready & rd_jobq_ready) |
                      (head_wr & wr_desc_ready & wr_jobq_ready) |
                      (~head_rd & ~head_wr);  // unknown mode is dropped

  dma_queue #(.payload_t(job_t)) u_rd_job_q (
    .clk(clk), .arst_n(arst_n),
    .in_data(head_job), .in_valid(head_rd & rd_desc_ready), .in_ready(rd_jobq_ready),
    .out_data(rd_job), .out_valid(rd_job_valid), .out_ready(rd_job_ready),
    .almost_full()
  );

  dma_queue #(.payload_t(job_t)) u_wr_job_q (
    .clk(clk), .arst_n(arst_n),
    .in_data(head_job), .in_valid(head_wr & wr_desc_ready), .in_ready(wr_jobq_ready),
    .out_data(wr_job), .out_valid(wr_job_valid), .out_ready(wr_job_ready),
    .almost_full()
  );

endmodule

`default_nettype wire

/* hdl/burst_req_gen.sv */
`default_nettype none

module burst_req_gen import dma_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  dma_desc_t  desc,
  input  logic       desc_valid,
  output logic       desc_ready,
  output burst_req_t req,
  output logic       req_valid,
  input  logic       req_ready
);

  fsm_state_e        state;
  logic [addr_w-1:0] base_addr;
  logic [addr_w-1:0] offset;      // word offset of current segment
  logic [cnt_w-1:0]  seg_len;
  logic [cnt_w-1:0]  seg_stride;
  logic [cnt_w-1:0]  seg_count;
  logic [cnt_w-1:0]  seg_idx;
  logic              desc_fire;
  logic              req_fire;
  logic              last_seg;

  assign desc_ready = (state == st_idle);
  assign req_valid  = (state == st_run);
  assign desc_fire  = desc_valid & desc_ready;
  assign req_fire   = req_valid & req_ready;
  assign last_seg   = (seg_idx == seg_count - 1'b1);

  assign req.addr = base_addr + (offset << log2_beat_bytes);
  assign req.len  = seg_len - 1'b1;

  always_ff @(posedge clk) begin
    if (desc_fire) begin
      base_addr  <= desc.ext_addr;
      seg_len    <= desc.len;
      seg_stride <= desc.seg_stride;
      seg_count  <= desc.seg_count;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      seg_idx <= '0;
      offset  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (desc_fire) begin
            state   <= st_run;
            seg_idx <= '0;
            offset  <= '0;
          end
        end
        st_run: begin
          if (req_fire) begin
            seg_idx <= seg_idx + 1'b1;
            offset  <= offset + addr_w'(seg_stride);
            if (last_seg)
              state <= st_done;
          end
        end
        default: state <= st_idle;  // one cycle in done
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/beat_tracker.sv */
`default_nettype none

module beat_tracker import dma_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  job_t     job,
  input  logic     job_valid,
  output logic     job_ready,
  input  payload_t src_data,
  input  logic     src_valid,
  output logic     src_ready,
  output payload_t dst_data,
  output logic     dst_valid,
  input  logic     dst_ready,
  output logic     last
);

  fsm_state_e       state;
  logic [cnt_w-1:0] seg_len;
  logic [cnt_w-1:0] seg_count;
  logic [cnt_w-1:0] beat_idx;   // beat within segment
  logic [cnt_w-1:0] seg_idx;
  logic             running;
  logic             beat_fire;
  logic             seg_end;

  assign job_ready = (state == st_idle);
  assign running   = (state == st_run);
  assign last      = (state == st_done);

  assign dst_data  = src_data;
  assign dst_valid = src_valid & running;
  assign src_ready = dst_ready & running;
  assign beat_fire = src_valid & dst_ready & running;
  assign seg_end   = (beat_idx == seg_len - 1'b1);

  always_ff @(posedge clk) begin
    if (job_valid && job_ready) begin
      seg_len   <= job.len;
      seg_count <= job.seg_count;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      beat_idx <= '0;
      seg_idx  <= '0;
    end else begin
      case (state)
        st_idle: begin
          beat_idx <= '0;
          seg_idx  <= '0;
          if (job_valid)
            state <= st_run;
        end
        st_run: begin
          if (beat_fire) begin
            beat_idx <= seg_end ? '0 : beat_idx + 1'b1;
            if (seg_end) begin
              seg_idx <= seg_idx + 1'b1;
              if (seg_idx == seg_count - 1'b1)
                state <= st_done;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/dma_engine.sv */
`default_nettype none

module dma_engine import dma_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,

  input  logic              dma_start,
  input  logic [1:0]        dma_mode,        // 1 read, 2 write
  input  logic [addr_w-1:0] dma_ext_addr,
  input  logic [cnt_w-1:0]  dma_len,
  input  logic [cnt_w-1:0]  dma_seg_stride,
  input  logic [cnt_w-1:0]  dma_seg_count,
  output logic              dma_done,
  output logic              dma_queue_wr_ready,

  output burst_req_t        ar_req,
  output logic              ar_valid,
  input  logic              ar_ready,
  input  logic [data_w-1:0] r_data,
  input  logic              r_valid,
  output logic              r_ready,

  output burst_req_t        aw_req,
  output logic              aw_valid,
  input  logic              aw_ready,
  output logic [data_w-1:0] w_data,
  output logic              w_valid,
  input  logic              w_ready,

  input  logic [data_w-1:0] enq_data,
  input  logic              enq_valid,
  output logic              enq_ready,

  output logic [data_w-1:0] deq_data,
  output logic              deq_valid,
  input  logic              deq_ready
);

  dma_desc_t cmd;
  dma_desc_t rd_desc;
  dma_desc_t wr_desc;
  logic      rd_desc_valid, rd_desc_ready;
  logic      wr_desc_valid, wr_desc_ready;
  job_t      rd_job;
  job_t      wr_job;
  logic      rd_job_valid, rd_job_ready;
  logic      wr_job_valid, wr_job_ready;
  logic      rd_last;
  logic      wr_last;

  assign cmd = '{mode: dma_mode_e'(dma_mode), ext_addr: dma_ext_addr, len: dma_len,
                 seg_stride: dma_seg_stride, seg_count: dma_seg_count};

  dma_dispatch u_dispatch (
    .clk(clk), .arst_n(arst_n),
    .start(dma_start), .cmd(cmd), .queue_wr_ready(dma_queue_wr_ready),
    .rd_desc(rd_desc), .rd_desc_valid(rd_desc_valid), .rd_desc_ready(rd_desc_ready),
    .wr_desc(wr_desc), .wr_desc_valid(wr_desc_valid), .wr_desc_ready(wr_desc_ready),
    .rd_job(rd_job), .rd_job_valid(rd_job_valid), .rd_job_ready(rd_job_ready),
    .wr_job(wr_job), .wr_job_valid(wr_job_valid), .wr_job_ready(wr_job_ready)
  );

  burst_req_gen u_rd_req (
    .clk(clk), .arst_n(arst_n),
    .desc(rd_desc), .desc_valid(rd_desc_valid), .desc_ready(rd_desc_ready),
    .req(ar_req), .req_valid(ar_valid), .req_ready(ar_ready)
  );

  burst_req_gen u_wr_req (
    .clk(clk), .arst_n(arst_n),
    .desc(wr_desc), .desc_valid(wr_desc_valid), .desc_ready(wr_desc_ready),
    .req(aw_req), .req_valid(aw_valid), .req_ready(aw_ready)
  );

  // read beats flow bus to deq port
  beat_tracker #(.payload_t(logic [data_w-1:0])) u_rd_beats (
    .clk(clk), .arst_n(arst_n),
    .job(rd_job), .job_valid(rd_job_valid), .job_ready(rd_job_ready),
    .src_data(r_data), .src_valid(r_valid), .src_ready(r_ready),
    .dst_data(deq_data), .dst_valid(deq_valid), .dst_ready(deq_ready),
    .last(rd_last)
  );

  beat_tracker #(.payload_t(logic [data_w-1:0])) u_wr_beats (
    .clk(clk), .arst_n(arst_n),
    .job(wr_job), .job_valid(wr_job_valid), .job_ready(wr_job_ready),
    .src_data(enq_data), .src_valid(enq_valid), .src_ready(enq_ready),
    .dst_data(w_data), .dst_valid(w_valid), .dst_ready(w_ready),
    .last(wr_last)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      dma_done <= 1'b0;
    else
      dma_done <= rd_last | wr_last;
  end

endmodule

`default_nettype wire

/* test/dma_mem_model.sv */
`default_nettype none

module dma_mem_model import dma_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req_hold,     // stalls both request channels
  input  burst_req_t        ar_req,
  input  logic              ar_valid,
  output logic              ar_ready,
  output logic [data_w-1:0] r_data,
  output logic              r_valid,
  input  logic              r_ready,
  input  burst_req_t        aw_req,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  logic [data_w-1:0] w_data,
  input  logic              w_valid,
  output logic              w_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  burst_req_t        ar_log [$];
  burst_req_t        aw_log [$];
  logic [data_w-1:0] w_log [$];
  burst_req_t        pending [$];   // accepted reads still to be served
  burst_req_t        burst;
  logic [addr_w-1:0] beat_addr;
  logic [cnt_w:0]    beats_left;
  logic              rv;

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ar_ready   <= 1'b0;
      aw_ready   <= 1'b0;
      w_ready    <= 1'b0;
      r_valid    <= 1'b0;
      r_data     <= '0;
      beats_left = '0;
    end else begin
      ar_ready <= !req_hold && ($urandom % 4 != 0);
      aw_ready <= !req_hold && ($urandom % 4 != 0);
      w_ready  <= ($urandom % 4 != 0);
      if (ar_valid && ar_ready) begin
        ar_log.push_back(ar_req);
        pending.push_back(ar_req);
      end
      if (aw_valid && aw_ready)
        aw_log.push_back(aw_req);
      if (w_valid && w_ready)
        w_log.push_back(w_data);

      rv = r_valid && !r_ready;  // beat still waiting for the sink
      if (!rv && beats_left == 0 && pending.size() != 0) begin
        burst      = pending.pop_front();
        beat_addr  = burst.addr;
        beats_left = {1'b0, burst.len} + 1'b1;
      end
      if (!rv && beats_left != 0 && $urandom % 4 != 0) begin
        r_data     <= {(data_w / addr_w){beat_addr}};
        beat_addr  = beat_addr + 64;
        beats_left = beats_left - 1'b1;
        rv = 1'b1;
      end
      r_valid <= rv;
    end
  end

endmodule

`default_nettype wire

/* test/dma_tb.sv */
`default_nettype none

module dma_tb import dma_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic              clk, arst_n;
  logic              dma_start, dma_done, dma_queue_wr_ready;
  logic [1:0]        dma_mode;
  logic [addr_w-1:0] dma_ext_addr;
  logic [cnt_w-1:0]  dma_len, dma_seg_stride, dma_seg_count;
  burst_req_t        ar_req, aw_req, ar_exp, aw_exp;
  logic              ar_valid, ar_ready, r_valid, r_ready;
  logic              aw_valid, aw_ready, w_valid, w_ready;
  logic              enq_valid, enq_ready, deq_valid, deq_ready;
  logic [data_w-1:0] r_data, w_data, enq_data, deq_data, deq_exp, w_exp;
  logic              req_hold, feed_en;

  // expected traffic is appended when a descriptor is issued
  burst_req_t        exp_ar [64];
  burst_req_t        exp_aw [64];
  logic [data_w-1:0] exp_deq [128];
  logic [data_w-1:0] w_words [128];   // enq stream and expected w_data
  int                exp_ar_n, exp_aw_n, exp_deq_n, exp_w_n;
  int                ar_cnt, aw_cnt, deq_cnt, w_cnt, enq_idx, done_cnt;
  int                errors, test_errs, passed, failed;

  dma_engine    dut (.*);
  dma_mem_model mem (.*);

  assign ar_exp  = exp_ar[ar_cnt];
  assign aw_exp  = exp_aw[aw_cnt];
  assign deq_exp = exp_deq[deq_cnt];
  assign w_exp   = w_words[w_cnt];

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
    deq_ready <= ($urandom % 3 != 0);  // random sink back-pressure

  // enq source holds valid until taken
  always @(posedge clk) begin
    int nxt;
    nxt = enq_idx + int'(enq_valid && enq_ready);
    enq_idx <= nxt;
    if (!(enq_valid && !enq_ready)) begin
      enq_valid <= feed_en && nxt < exp_w_n && ($urandom % 3 != 0);
      enq_data  <= w_words[nxt];
    end
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ar_cnt   <= 0;
      aw_cnt   <= 0;
      deq_cnt  <= 0;
      w_cnt    <= 0;
      done_cnt <= 0;
    end else begin
      ar_cnt   <= ar_cnt + int'(ar_valid && ar_ready);
      aw_cnt   <= aw_cnt + int'(aw_valid && aw_ready);
      deq_cnt  <= deq_cnt + int'(deq_valid && deq_ready);
      w_cnt    <= w_cnt + int'(w_valid && w_ready);
      done_cnt <= done_cnt + int'(dma_done);
    end
  end

  task automatic mismatch(string name, logic [data_w-1:0] got, logic [data_w-1:0] exp);
    $display("error: %s got %0h expected %0h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic expect_val(string name, logic [data_w-1:0] got, logic [data_w-1:0] exp);
    assert (got === exp) else mismatch(name, got, exp);
  endtask

  assert property (@(posedge clk) disable iff (!arst_n) ar_valid && ar_ready |-> ar_req == ar_exp)
    else mismatch("ar_req", $sampled(ar_req), $sampled(ar_exp));
  assert property (@(posedge clk) disable iff (!arst_n) aw_valid && aw_ready |-> aw_req == aw_exp)
    else mismatch("aw_req", $sampled(aw_req), $sampled(aw_exp));
  assert property (@(posedge clk) disable iff (!arst_n)
                   deq_valid && deq_ready |-> deq_data == deq_exp)
    else mismatch("deq_data", $sampled(deq_data), $sampled(deq_exp));
  assert property (@(posedge clk) disable iff (!arst_n) w_valid && w_ready |-> w_data == w_exp)
    else mismatch("w_data", $sampled(w_data), $sampled(w_exp));
  assert property (@(posedge clk) disable iff (!arst_n) w_valid |-> enq_valid) else begin
    $display("w_valid is high while enq_valid is low at %0t", $time);
    errors++;
  end
  assert property (@(posedge clk) disable iff (!arst_n) dma_done |=> !dma_done)
    else mismatch("dma_done", 1'b1, 1'b0);

  task automatic issue(dma_mode_e mode, int hold);
    logic [addr_w-1:0] addr;
    logic [addr_w-1:0] beat;
    logic [cnt_w-1:0]  len;
    logic [cnt_w-1:0]  stride;
    logic [cnt_w-1:0]  count;
    logic [data_w-1:0] word;
    addr   = {$urandom(), $urandom()};
    len    = 1 + $urandom % 4;
    stride = $urandom % 8;
    count  = 1 + $urandom % 3;
    for (int k = 0; k < count; k++) begin
      beat = addr + k * stride * 64;
      if (mode == mode_read) begin
        exp_ar[exp_ar_n] = '{addr: beat, len: len - 1};
        exp_ar_n++;
      end else begin
        exp_aw[exp_aw_n] = '{addr: beat, len: len - 1};
        exp_aw_n++;
      end
      for (int i = 0; i < len; i++) begin
        if (mode == mode_read) begin
          exp_deq[exp_deq_n] = {(data_w / addr_w){beat}};
          exp_deq_n++;
        end else begin
          for (int j = 0; j < data_w / 32; j++)
            word[j*32 +: 32] = $urandom;
          w_words[exp_w_n] = word;
          exp_w_n++;
        end
        beat = beat + 64;
      end
    end
    @(posedge clk);
    dma_mode       <= mode;
    dma_ext_addr   <= addr;
    dma_len        <= len;
    dma_seg_stride <= stride;
    dma_seg_count  <= count;
    dma_start      <= 1'b1;
    repeat (hold) @(posedge clk);
    dma_start <= 1'b0;
  endtask

  task automatic wait_all(int target);
    int cycles;
    cycles = 0;
    while (done_cnt < target || ar_cnt < exp_ar_n || aw_cnt < exp_aw_n) begin
      if (cycles == 5000) begin
        $display("timeout: only %0d of %0d descriptors finished", done_cnt, target);
        errors++;
        break;
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic finish_test(int num, string name);
    if (errors == test_errs) begin
      passed++;
      $display("test %0d %s: ok", num, name);
    end else begin
      failed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  initial begin
    void'($urandom(32'h86be931e));
    arst_n         = 1'b0;
    dma_start      = 1'b0;
    dma_mode       = '0;
    dma_ext_addr   = '0;
    dma_len        = '0;
    dma_seg_stride = '0;
    dma_seg_count  = '0;
    enq_data       = '0;
    enq_valid      = 1'b0;
    deq_ready      = 1'b0;
    req_hold       = 1'b0;
    feed_en        = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    expect_val("ar_valid", ar_valid, 0);
    expect_val("aw_valid", aw_valid, 0);
    expect_val("w_valid", w_valid, 0);
    expect_val("deq_valid", deq_valid, 0);
    expect_val("enq_ready", enq_ready, 0);
    expect_val("r_ready", r_ready, 0);
    expect_val("dma_done", dma_done, 0);
    expect_val("dma_queue_wr_ready", dma_queue_wr_ready, 1);
    finish_test(1, "reset values");

    issue(mode_read, 1);
    wait_all(1);
    expect_val("ar_log size", mem.ar_log.size(), exp_ar_n);
    finish_test(2, "read requests");

    issue(mode_read, 1);
    wait_all(2);
    expect_val("deq beat count", deq_cnt, exp_deq_n);
    finish_test(3, "read data under back-pressure");

    feed_en <= 1'b1;
    issue(mode_write, 1);
    wait_all(3);
    expect_val("aw_log size", mem.aw_log.size(), exp_aw_n);
    expect_val("w_log size", mem.w_log.size(), exp_w_n);
    finish_test(4, "write requests and data");

    issue(mode_read, 20);  // start held high
    wait_all(4);
    repeat (40) @(posedge clk);
    expect_val("done count", done_cnt, 4);
    expect_val("ar_log size", mem.ar_log.size(), exp_ar_n);
    finish_test(5, "one done per descriptor");

    // stalled bus lets the descriptor queue fill
    feed_en  <= 1'b0;
    req_hold <= 1'b1;
    issue(mode_read, 1);
    issue(mode_read, 1);
    issue(mode_write, 1);
    issue(mode_write, 1);
    for (int i = 0; i < 20 && dma_queue_wr_ready; i++)
      @(negedge clk);
    expect_val("dma_queue_wr_ready", dma_queue_wr_ready, 0);
    req_hold <= 1'b0;
    wait_all(6);
    feed_en <= 1'b1;  // writes finish well after the reads
    wait_all(8);
    repeat (20) @(posedge clk);
    expect_val("done count", done_cnt, 8);
    expect_val("deq beat count", deq_cnt, exp_deq_n);
    expect_val("w beat count", w_cnt, exp_w_n);
    finish_test(6, "queued mixed descriptors");

    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0 && errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hdl/dma_pkg.sv
hdl/dma_queue.sv
hdl/dma_dispatch.sv
hdl/burst_req_gen.sv
hdl/beat_tracker.sv
hdl/dma_engine.sv
test/dma_mem_model.sv
test/dma_tb.sv
